/* build.f */
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/control.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/rv_core.sv
bench/tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_rv_core -o tb_rv_core

./obj_dir/tb_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
exit 0

/* bench/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic [31:0] pc, mem_addr, mem_wdata, mem_rdata;
	logic        mem_we, mem_re, fence, illegal;

	// reference model state and the expected outputs of the current cycle
	logic [31:0] m_regs [32];
	logic [31:0] m_pc;
	logic [31:0] exp_addr, exp_wdata;
	logic        exp_we, exp_re, exp_fence, exp_illegal;
	logic [31:0] seed;
	int          errors;
	int          tests;

	rv_core i_dut (
		.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr), .pc(pc),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
		.mem_we(mem_we), .mem_re(mem_re), .fence(fence), .illegal(illegal)
	);

	// word memory contents depend on every address bit
	function automatic logic [31:0] mem_word(input logic [31:0] a);
		return {a[15:0] ^ 16'h3c5a, ~a[31:16]} + {a[7:0], 24'h0};
	endfunction

	assign mem_rdata = mem_word(mem_addr);

	function logic [31:0] next_rand();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	function automatic void flag_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		errors++;
		$display("FAIL %s: got %h exp %h", name, got, exp);
	endfunction

	function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] u_format(input logic [31:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm[31:12], rd, op};
	endfunction

	function automatic logic [31:0] j_format(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	// alt selects sub or arithmetic right shift
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return {31'h0, $signed(a) < $signed(b)};
			3'd3:    return {31'h0, a < b};
			3'd4:    return a ^ b;
			3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0:    return a == b;
			3'd1:    return a != b;
			3'd4:    return $signed(a) < $signed(b);
			3'd5:    return $signed(a) >= $signed(b);
			3'd6:    return a < b;
			default: return a >= b;
		endcase
	endfunction

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#400000;
		$display("timeout: simulation ran far too long");
		$display("ERRORS FOUND");
		$finish;
	end

	a_pc: assert property (@(posedge clk) disable iff (!rst_n) pc == m_pc)
		else flag_mismatch("pc", pc, m_pc);
	a_we: assert property (@(posedge clk) disable iff (!rst_n) mem_we == exp_we)
		else flag_mismatch("mem_we", 32'(mem_we), 32'(exp_we));
	a_re: assert property (@(posedge clk) disable iff (!rst_n) mem_re == exp_re)
		else flag_mismatch("mem_re", 32'(mem_re), 32'(exp_re));
	a_addr: assert property (@(posedge clk) disable iff (!rst_n)
		(exp_we || exp_re) |-> mem_addr == exp_addr)
		else flag_mismatch("mem_addr", mem_addr, exp_addr);
	a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
		exp_we |-> mem_wdata == exp_wdata)
		else flag_mismatch("mem_wdata", mem_wdata, exp_wdata);
	a_fence: assert property (@(posedge clk) disable iff (!rst_n) fence == exp_fence)
		else flag_mismatch("fence", 32'(fence), 32'(exp_fence));
	a_illegal: assert property (@(posedge clk) disable iff (!rst_n) illegal == exp_illegal)
		else flag_mismatch("illegal", 32'(illegal), 32'(exp_illegal));

	// presents one instruction for one cycle and steps the model at the edge
	task automatic issue(input logic [31:0] ins);
		logic [31:0] a, b, ii, res, nxt;
		logic [2:0]  f3;
		logic        wr;
		f3 = ins[14:12];
		a = m_regs[ins[19:15]];
		b = m_regs[ins[24:20]];
		ii = {{20{ins[31]}}, ins[31:20]};
		wr = 1'b0;
		res = '0;
		nxt = m_pc + 4;
		case (ins[6:0])
			7'h33: begin
				wr = 1'b1;
				res = alu_ref(f3, ins[30], a, b);
			end
			7'h13: begin
				wr = 1'b1;
				res = alu_ref(f3, (f3 == 3'd5) && ins[30], a, ii);
			end
			7'h03: begin
				exp_re = 1'b1;
				exp_addr = a + ii;
				wr = 1'b1;
				res = mem_word(exp_addr);
			end
			7'h23: begin
				exp_we = 1'b1;
				exp_addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				exp_wdata = b;
			end
			7'h63: begin
				if (branch_ref(f3, a, b))
					nxt = m_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			end
			7'h6f: begin
				wr = 1'b1;
				res = m_pc + 4;
				nxt = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			7'h67: begin
				wr = 1'b1;
				res = m_pc + 4;
				nxt = (a + ii) & ~32'h1;
			end
			7'h37: begin
				wr = 1'b1;
				res = {ins[31:12], 12'h0};
			end
			7'h17: begin
				wr = 1'b1;
				res = m_pc + {ins[31:12], 12'h0};
			end
			7'h0f: exp_fence = 1'b1;
			default: exp_illegal = 1'b1;
		endcase
		instr = ins;
		instr_valid = 1'b1;
		@(posedge clk);
		if (wr && ins[11:7] != 5'd0)
			m_regs[ins[11:7]] = res;
		m_pc = nxt;
		#1;
		instr_valid = 1'b0;
		{exp_we, exp_re, exp_fence, exp_illegal} = 4'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic load_reg(input logic [4:0] r, input logic [31:0] v);
		issue(u_format(v + 32'h800, r, 7'h37));
		issue(i_format(v[11:0], r, 3'd0, r, 7'h13));
	endtask

	task automatic store_reg(input logic [4:0] r);
		issue(s_format(12'(next_rand()) & 12'hffc, r, 5'd0));
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("test %s finished, errors so far %0d", name, errors);
	endtask

	initial begin
		logic [31:0] a, b;
		logic [2:0]  f3;
		int          cnt;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		seed = 32'hed59_b7ab;
		errors = 0;
		tests = 0;
		m_pc = '0;
		{exp_we, exp_re, exp_fence, exp_illegal} = 4'b0;
		exp_addr = '0;
		exp_wdata = '0;
		for (int i = 0; i < 32; i++)
			m_regs[i] = '0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		cnt = 0;
		while (pc !== 32'h0 && cnt < 10) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		if (pc !== 32'h0) begin
			errors++;
			$display("timeout: pc never settled at the reset value");
		end
		idle(4);
		report_test("reset");

		for (int k = 0; k < 4; k++) begin
			load_reg(5'd1, next_rand());
			load_reg(5'd2, (k == 0) ? m_regs[1] : next_rand());
			for (int f = 0; f < 8; f++) begin
				issue(r_format(7'h00, 5'd2, 5'd1, f[2:0], 5'd3));
				store_reg(5'd3);
				issue(i_format((f == 1 || f == 5) ? {7'h00, 5'(next_rand())} :
					12'(next_rand()), 5'd1, f[2:0], 5'd4, 7'h13));
				store_reg(5'd4);
			end
			issue(r_format(7'h20, 5'd2, 5'd1, 3'd0, 5'd3));
			store_reg(5'd3);
			issue(r_format(7'h20, 5'd2, 5'd1, 3'd5, 5'd3));
			store_reg(5'd3);
			issue(i_format({7'h20, 5'(next_rand())}, 5'd1, 3'd5, 5'd4, 7'h13));
			store_reg(5'd4);
		end
		issue(i_format(12'h7ff, 5'd1, 3'd0, 5'd0, 7'h13));
		store_reg(5'd0);
		report_test("alu");

		for (int k = 0; k < 6; k++) begin
			load_reg(5'd5, next_rand());
			issue(i_format(12'(next_rand()), 5'd5, 3'd2, 5'd6, 7'h03));
			store_reg(5'd6);
		end
		report_test("load_store");

		for (int k = 0; k < 24; k++) begin
			f3 = (k % 6 < 2) ? 3'(k % 6) : 3'(k % 6 + 2);
			a = next_rand();
			b = (k < 6) ? a : ((k < 12) ? a ^ 32'h8000_0000 : next_rand());
			load_reg(5'd1, a);
			load_reg(5'd2, b);
			issue(b_format(13'(next_rand()) & 13'h1ffe, 5'd2, 5'd1, f3));
		end
		issue(j_format(21'(next_rand()) & 21'h1ffffe, 5'd7));
		store_reg(5'd7);
		// even base and odd offset leave bit 0 of the target set
		load_reg(5'd5, next_rand() & ~32'h1);
		issue(i_format(12'(next_rand()) | 12'h1, 5'd5, 3'd0, 5'd8, 7'h67));
		store_reg(5'd8);
		report_test("control_flow");

		issue(u_format(next_rand(), 5'd9, 7'h37));
		store_reg(5'd9);
		issue(u_format(next_rand(), 5'd10, 7'h17));
		store_reg(5'd10);
		report_test("upper_imm");

		issue(32'h0000_000f);
		idle(1);
		load_reg(5'd3, next_rand());
		issue(i_format(12'h305, 5'd1, 3'd1, 5'd3, 7'h73));
		issue(i_format(12'h123, 5'd1, 3'd0, 5'd3, 7'h7f));
		store_reg(5'd3);
		idle(2);
		report_test("fence_illegal");

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_valid,
	input  logic [`RV_XLEN-1:0] instr,
	output logic [`RV_XLEN-1:0] pc,
	output logic [`RV_XLEN-1:0] mem_addr,
	output logic [`RV_XLEN-1:0] mem_wdata,
	input  logic [`RV_XLEN-1:0] mem_rdata,
	output logic                mem_we,
	output logic                mem_re,
	output logic                fence,
	output logic                illegal
);
	import rv_ctrl_pkg::*;

	logic [`RV_REG_AW-1:0] rs1, rs2, rd;
	alu_op_e               alu_op;
	pc_sel_e               pc_sel;
	logic                  alu_src_imm, pc_src_a;
	logic                  reg_write, mem_to_reg, mem_read, mem_write;
	logic                  is_fence, is_illegal;
	logic [`RV_XLEN-1:0]   imm;
	logic [`RV_XLEN-1:0]   rs1_data, rs2_data;
	logic [`RV_XLEN-1:0]   alu_a, alu_b, alu_result;
	logic                  taken;
	logic [`RV_XLEN-1:0]   pc_plus4, pc_target, pc_next, wb_data;
	logic                  link;

	control i_control (
		.instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .alu_op(alu_op),
		.alu_src_imm(alu_src_imm), .pc_src_a(pc_src_a), .reg_write(reg_write),
		.mem_to_reg(mem_to_reg), .mem_read(mem_read), .mem_write(mem_write),
		.pc_sel(pc_sel), .imm(imm), .is_fence(is_fence), .is_illegal(is_illegal)
	);

	reg_file i_reg_file (
		.clk(clk), .rst_n(rst_n), .raddr1(rs1), .raddr2(rs2),
		.rdata1(rs1_data), .rdata2(rs2_data),
		.we(instr_valid && reg_write), .waddr(rd), .wdata(wb_data)
	);

	// auipc takes the pc as operand a
	assign alu_a = pc_src_a ? pc : rs1_data;
	assign alu_b = alu_src_imm ? imm : rs2_data;

	alu i_alu (
		.op(alu_op), .a(alu_a), .b(alu_b), .funct3(instr[14:12]),
		.result(alu_result), .taken(taken)
	);

	assign pc_plus4  = pc + 32'd4;
	assign pc_target = pc + imm;

	always_comb begin
		case (pc_sel)
			PC_BRANCH: pc_next = taken ? pc_target : pc_plus4;
			PC_JAL:    pc_next = pc_target;
			PC_JALR:   pc_next = {alu_result[`RV_XLEN-1:1], 1'b0};
			default:   pc_next = pc_plus4;
		endcase
	end

	// jumps write the return address
	assign link    = (pc_sel == PC_JAL) || (pc_sel == PC_JALR);
	assign wb_data = mem_to_reg ? mem_rdata : (link ? pc_plus4 : alu_result);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `RV_RESET_PC;
		end else if (instr_valid) begin
			pc <= pc_next;
		end
	end

	assign mem_we    = instr_valid && mem_write;
	assign mem_re    = instr_valid && mem_read;
	assign mem_addr  = (mem_we || mem_re) ? alu_result : '0;
	assign mem_wdata = mem_we ? rs2_data : '0;
	assign fence     = instr_valid && is_fence;
	assign illegal   = instr_valid && is_illegal;

	a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n) !(mem_we && mem_re))
		else $error("rv_core: read and write strobes both high");

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module alu (
	input  rv_ctrl_pkg::alu_op_e op,
	input  logic [`RV_XLEN-1:0]  a,
	input  logic [`RV_XLEN-1:0]  b,
	input  logic [2:0]           funct3,
	output logic [`RV_XLEN-1:0]  result,
	output logic                 taken
);
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign shamt = b[4:0];
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb begin
		case (op)
			ALU_ADD:    result = a + b;
			ALU_SUB:    result = a - b;
			ALU_SLL:    result = a << shamt;
			ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, lt_s};
			ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, lt_u};
			ALU_XOR:    result = a ^ b;
			ALU_SRL:    result = a >> shamt;
			ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
			ALU_OR:     result = a | b;
			ALU_AND:    result = a & b;
			ALU_PASS_B: result = b;
			default:    result = '0;
		endcase
	end

	// branch condition, only meaningful when the core selects PC_BRANCH
	always_comb begin
		case (funct3)
			F3_BEQ:  taken = (a == b);
			F3_BNE:  taken = (a != b);
			F3_BLT:  taken = lt_s;
			F3_BGE:  taken = !lt_s;
			F3_BLTU: taken = lt_u;
			F3_BGEU: taken = !lt_u;
			default: taken = 1'b0;
		endcase
	end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module reg_file (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`RV_REG_AW-1:0] raddr1,
	input  logic [`RV_REG_AW-1:0] raddr2,
	output logic [`RV_XLEN-1:0]   rdata1,
	output logic [`RV_XLEN-1:0]   rdata2,
	input  logic                  we,
	input  logic [`RV_REG_AW-1:0] waddr,
	input  logic [`RV_XLEN-1:0]   wdata
);

	logic [`RV_XLEN-1:0] regs [`RV_NREGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 reads as zero on both ports
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		((raddr1 == '0) |-> (rdata1 == '0)) and ((raddr2 == '0) |-> (rdata2 == '0)))
		else $error("reg_file: x0 read returned nonzero");

endmodule

/* hdl/control.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module control (
	input  logic [`RV_XLEN-1:0]   instr,
	output logic [`RV_REG_AW-1:0] rs1,
	output logic [`RV_REG_AW-1:0] rs2,
	output logic [`RV_REG_AW-1:0] rd,
	output rv_ctrl_pkg::alu_op_e  alu_op,
	output logic                  alu_src_imm,
	output logic                  pc_src_a,
	output logic                  reg_write,
	output logic                  mem_to_reg,
	output logic                  mem_read,
	output logic                  mem_write,
	output rv_ctrl_pkg::pc_sel_e  pc_sel,
	output logic [`RV_XLEN-1:0]   imm,
	output logic                  is_fence,
	output logic                  is_illegal
);
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;

	opcode_e              opcode;
	logic [2:0]           funct3;
	logic [`RV_XLEN-1:0]  imm_i;
	logic [`RV_XLEN-1:0]  imm_s;
	logic [`RV_XLEN-1:0]  imm_b;
	logic [`RV_XLEN-1:0]  imm_u;
	logic [`RV_XLEN-1:0]  imm_j;

	// bit 30 only means sub/sra for R-type, for ALUI it is an immediate bit except on shifts
	function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
			input logic is_reg);
		alu_op_e op;
		case (f3)
			F3_ADD:  op = (is_reg && alt) ? ALU_SUB : ALU_ADD;
			F3_SLL:  op = ALU_SLL;
			F3_SLT:  op = ALU_SLT;
			F3_SLTU: op = ALU_SLTU;
			F3_XOR:  op = ALU_XOR;
			F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
			F3_OR:   op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign rd     = instr[11:7];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];

	// all immediates leave here fully sign-extended
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		alu_op      = ALU_ADD;
		alu_src_imm = 1'b0;
		pc_src_a    = 1'b0;
		reg_write   = 1'b0;
		mem_to_reg  = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		pc_sel      = PC_SEQ;
		imm         = '0;
		is_fence    = 1'b0;
		is_illegal  = 1'b0;
		case (opcode)
			OP_R: begin
				reg_write = 1'b1;
				alu_op    = alu_decode(funct3, instr[30], 1'b1);
			end
			OP_ALUI: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				imm         = imm_i;
				alu_op      = alu_decode(funct3, instr[30], 1'b0);
			end
			OP_LOAD: begin
				reg_write   = 1'b1;
				mem_to_reg  = 1'b1;
				mem_read    = 1'b1;
				alu_src_imm = 1'b1;
				imm         = imm_i;
			end
			OP_STORE: begin
				mem_write   = 1'b1;
				alu_src_imm = 1'b1;
				imm         = imm_s;
			end
			OP_BRANCH: begin
				// alu compares rs1 with rs2, target is formed in the core
				pc_sel = PC_BRANCH;
				alu_op = ALU_SUB;
				imm    = imm_b;
			end
			OP_JAL: begin
				reg_write = 1'b1;
				pc_sel    = PC_JAL;
				imm       = imm_j;
			end
			OP_JALR: begin
				reg_write   = 1'b1;
				pc_sel      = PC_JALR;
				alu_src_imm = 1'b1;
				imm         = imm_i;
			end
			OP_LUI: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				alu_op      = ALU_PASS_B;
				imm         = imm_u;
			end
			OP_AUIPC: begin
				reg_write   = 1'b1;
				pc_src_a    = 1'b1;
				alu_src_imm = 1'b1;
				imm         = imm_u;
			end
			OP_FENCE: begin
				is_fence = 1'b1;
			end
			// csr and environment calls are not implemented
			OP_SYSTEM: begin
				is_illegal = 1'b1;
			end
			default: begin
				is_illegal = 1'b1;
			end
		endcase
	end

	always_comb begin
		assert (!(mem_read && mem_write))
			else $error("control: load and store decoded together");
	end

endmodule

/* hdl/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

	// operation selected by the decoder for the alu
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_op_e;

	// source of the next program counter
	typedef enum logic [1:0] {
		PC_SEQ    = 2'd0,
		PC_BRANCH = 2'd1,
		PC_JAL    = 2'd2,
		PC_JALR   = 2'd3
	} pc_sel_e;

endpackage

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

	// major opcodes, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		OP_R      = 7'b0110011,
		OP_ALUI   = 7'b0010011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_FENCE  = 7'b0001111,
		OP_SYSTEM = 7'b1110011
	} opcode_e;

	// branch conditions
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// register and immediate alu subtypes
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

endpackage

/* hdl/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data path and address width
`define RV_XLEN 32

// architectural register count, x0 included
`define RV_NREGS 32

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// register index width
`define RV_REG_AW 5

`endif
